// File: logic/bus_pkg.sv
package bus_pkg;

    localparam int unsigned addr_w = 32;
    localparam int unsigned data_w = 32;
    localparam int unsigned resp_w = 2;

    // one byte address on the fabric.
    typedef logic [addr_w-1:0] addr_t;

    // read or write data word.
    typedef logic [data_w-1:0] data_t;

    // response code, encoded as on AXI-Lite.
    typedef logic [resp_w-1:0] resp_t;

    localparam resp_t resp_okay   = resp_t'(2'b00);
    localparam resp_t resp_decerr = resp_t'(2'b11);

    // the arbiter holds one transaction at a time.
    // paused is only entered from idle, so nothing is in flight there.
    typedef enum logic [1:0] {
        arb_idle   = 2'd0,
        arb_busy   = 2'd1,
        arb_paused = 2'd2
    } arb_state_t;

endpackage

// File: logic/mmap_pkg.sv
package mmap_pkg;
    import bus_pkg::*;

    // target zero starts here, the others follow at a fixed stride.
    localparam addr_t mmap_base = addr_t'(32'h4000_0000);

    // distance between the bases of two neighbouring targets.
    localparam addr_t mmap_stride = addr_t'(32'h0000_1000);

    // low address bits that fall inside one target region.
    localparam int unsigned mmap_region_bits = 12;

    // bytes covered by one target region.
    // with the stride equal to this size, the regions sit back to back.
    localparam addr_t mmap_region_size = addr_t'(1) << mmap_region_bits;

    // base address of target idx.
    function automatic addr_t mmap_region_base(input int unsigned idx);
        addr_t offset;
        offset = addr_t'(idx) * mmap_stride;
        return mmap_base + offset;
    endfunction

    // true when addr lies inside the region of target idx.
    function automatic logic mmap_in_region(input addr_t addr, input int unsigned idx);
        addr_t lo;
        lo = mmap_region_base(idx);
        return (addr >= lo) && (addr - lo < mmap_region_size);
    endfunction

endpackage

// File: logic/fabric_arbiter.sv
`timescale 1ns/1ps

module fabric_arbiter import bus_pkg::*; #(
    parameter int unsigned num_msts  = 3,
    localparam int unsigned mst_idx_w = $clog2(num_msts)
) (
    input  logic                 hsdom_seq,
    input  logic                 arst_n,

    input  logic [num_msts-1:0]  mst_req_valid,
    output logic [num_msts-1:0]  mst_req_ready,

    input  logic                 pause_req,
    output logic                 pause_ack,

    output logic                 grant_valid,
    output logic [mst_idx_w-1:0] grant_idx,
    input  logic                 done
);

    arb_state_t state;

    logic [mst_idx_w-1:0] last_idx;
    logic [mst_idx_w-1:0] pick_idx;
    logic                 pick_found;

    // rotate priority so that the master after the last winner is tried first.
    always_comb begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int unsigned k = 1; k <= num_msts; k++) begin
            cand = (int'(last_idx) + k) % num_msts;
            if (!pick_found && mst_req_valid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = mst_idx_w'(cand);
            end
        end
    end

    always_ff @(posedge hsdom_seq or negedge arst_n) begin
        if (!arst_n) begin
            state         <= arb_idle;
            last_idx      <= mst_idx_w'(num_msts - 1);
            grant_valid   <= 1'b0;
            grant_idx     <= '0;
            mst_req_ready <= '0;
        end else begin
            // grant and ready are single-cycle strobes.
            grant_valid   <= 1'b0;
            mst_req_ready <= '0;

            case (state)
                arb_idle: begin
                    // a pause request wins over any pending request.
                    if (pause_req) begin
                        state <= arb_paused;
                    end else if (pick_found) begin
                        state                   <= arb_busy;
                        grant_valid             <= 1'b1;
                        grant_idx               <= pick_idx;
                        last_idx                <= pick_idx;
                        mst_req_ready[pick_idx] <= 1'b1;
                    end
                end

                arb_busy: begin
                    // stay here until the decoder has returned the response.
                    if (done) begin
                        state <= arb_idle;
                    end
                end

                arb_paused: begin
                    if (!pause_req) begin
                        state <= arb_idle;
                    end
                end

                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    // the paused state is only reachable from idle, so nothing is in flight
    // while the acknowledge is high.
    assign pause_ack = (state == arb_paused);

endmodule

// File: logic/fabric_decoder.sv
`timescale 1ns/1ps

module fabric_decoder import bus_pkg::*, mmap_pkg::*; #(
    parameter int unsigned num_msts  = 3,
    parameter int unsigned num_slvs  = 4,
    localparam int unsigned mst_idx_w = $clog2(num_msts),
    localparam int unsigned slv_idx_w = (num_slvs > 1) ? $clog2(num_slvs) : 1
) (
    input  logic                 hsdom_seq,
    input  logic                 arst_n,

    input  logic                 grant_valid,
    input  logic [mst_idx_w-1:0] grant_idx,

    input  logic [num_msts-1:0]  mst_req_write,
    input  addr_t                mst_req_addr  [num_msts],
    input  data_t                mst_req_wdata [num_msts],

    output logic [num_msts-1:0]  mst_rsp_valid,
    output data_t                mst_rsp_rdata [num_msts],
    output resp_t                mst_rsp_resp  [num_msts],

    output logic [num_slvs-1:0]  slv_req,
    output logic                 slv_write,
    output addr_t                slv_addr,
    output data_t                slv_wdata,

    input  logic [num_slvs-1:0]  slv_rsp,
    input  data_t                slv_rdata [num_slvs],
    input  resp_t                slv_resp  [num_slvs],

    output logic                 done
);

    addr_t                req_addr;
    addr_t                req_offset;
    addr_t                req_region;
    logic                 req_mapped;
    logic [slv_idx_w-1:0] req_tgt;

    logic                 pending;
    logic [slv_idx_w-1:0] tgt_q;
    logic [mst_idx_w-1:0] owner_q;
    logic                 rsp_hit;

    data_t rsp_rdata;
    resp_t rsp_resp;

    // addresses below the base wrap to a large offset and fail the check too.
    assign req_addr   = mst_req_addr[grant_idx];
    assign req_offset = req_addr - mmap_base;
    assign req_region = req_offset >> mmap_region_bits;
    assign req_mapped = (req_region < addr_t'(num_slvs));
    assign req_tgt    = slv_idx_w'(req_region);

    // only the target that was addressed may answer.
    assign rsp_hit = pending && slv_rsp[tgt_q];

    always_ff @(posedge hsdom_seq or negedge arst_n) begin
        if (!arst_n) begin
            slv_req       <= '0;
            mst_rsp_valid <= '0;
            done          <= 1'b0;
            pending       <= 1'b0;
            tgt_q         <= '0;
            owner_q       <= '0;
        end else begin
            slv_req       <= '0;
            mst_rsp_valid <= '0;
            done          <= 1'b0;

            if (grant_valid) begin
                owner_q <= grant_idx;
                if (req_mapped) begin
                    slv_req[req_tgt] <= 1'b1;
                    pending          <= 1'b1;
                    tgt_q            <= req_tgt;
                end else begin
                    // unmapped, so the fabric answers on its own.
                    mst_rsp_valid[grant_idx] <= 1'b1;
                    done                     <= 1'b1;
                end
            end else if (rsp_hit) begin
                pending                <= 1'b0;
                mst_rsp_valid[owner_q] <= 1'b1;
                done                   <= 1'b1;
            end
        end
    end

    always_ff @(posedge hsdom_seq) begin
        if (grant_valid) begin
            slv_write <= mst_req_write[grant_idx];
            slv_addr  <= req_addr;
            slv_wdata <= mst_req_wdata[grant_idx];
            if (!req_mapped) begin
                rsp_rdata <= '0;
                rsp_resp  <= resp_decerr;
            end
        end else if (rsp_hit) begin
            rsp_rdata <= slv_rdata[tgt_q];
            rsp_resp  <= slv_resp[tgt_q];
        end
    end

    // only the requester sees the response fields, the others read zero.
    for (genvar i = 0; i < num_msts; i++) begin : g_rsp
        assign mst_rsp_rdata[i] = mst_rsp_valid[i] ? rsp_rdata : '0;
        assign mst_rsp_resp[i]  = mst_rsp_valid[i] ? rsp_resp : resp_okay;
    end

endmodule

// File: logic/fabric_top.sv
`timescale 1ns/1ps

module fabric_top import bus_pkg::*; #(
    parameter int unsigned num_msts = 3,
    parameter int unsigned num_slvs = 4
) (
    input  logic                hsdom_seq,
    input  logic                arst_n,

    input  logic [num_msts-1:0] mst_req_valid,
    input  logic [num_msts-1:0] mst_req_write,
    input  addr_t               mst_req_addr  [num_msts],
    input  data_t               mst_req_wdata [num_msts],
    output logic [num_msts-1:0] mst_req_ready,

    output logic [num_msts-1:0] mst_rsp_valid,
    output data_t               mst_rsp_rdata [num_msts],
    output resp_t               mst_rsp_resp  [num_msts],

    output logic [num_slvs-1:0] slv_req,
    output logic                slv_write,
    output addr_t               slv_addr,
    output data_t               slv_wdata,

    input  logic [num_slvs-1:0] slv_rsp,
    input  data_t               slv_rdata [num_slvs],
    input  resp_t               slv_resp  [num_slvs],

    input  logic                pause_req,
    output logic                pause_ack
);

    localparam int unsigned mst_idx_w = $clog2(num_msts);

    logic                 grant_valid;
    logic [mst_idx_w-1:0] grant_idx;
    logic                 done;

    fabric_arbiter #(
        .num_msts (num_msts)
    ) i_arbiter (
        .hsdom_seq     (hsdom_seq),
        .arst_n        (arst_n),

        .mst_req_valid (mst_req_valid),
        .mst_req_ready (mst_req_ready),

        .pause_req     (pause_req),
        .pause_ack     (pause_ack),

        .grant_valid   (grant_valid),
        .grant_idx     (grant_idx),
        .done          (done)
    );

    fabric_decoder #(
        .num_msts (num_msts),
        .num_slvs (num_slvs)
    ) i_decoder (
        .hsdom_seq     (hsdom_seq),
        .arst_n        (arst_n),

        .grant_valid   (grant_valid),
        .grant_idx     (grant_idx),

        .mst_req_write (mst_req_write),
        .mst_req_addr  (mst_req_addr),
        .mst_req_wdata (mst_req_wdata),

        .mst_rsp_valid (mst_rsp_valid),
        .mst_rsp_rdata (mst_rsp_rdata),
        .mst_rsp_resp  (mst_rsp_resp),

        .slv_req       (slv_req),
        .slv_write     (slv_write),
        .slv_addr      (slv_addr),
        .slv_wdata     (slv_wdata),

        .slv_rsp       (slv_rsp),
        .slv_rdata     (slv_rdata),
        .slv_resp      (slv_resp),

        .done          (done)
    );

endmodule

// File: test/fabric_props.sv
`timescale 1ns/1ps

module fabric_props import bus_pkg::*, mmap_pkg::*; #(
    parameter int unsigned num_msts = 3,
    parameter int unsigned num_slvs = 4
) (
    input logic                hsdom_seq,
    input logic                arst_n,

    input logic [num_msts-1:0] mst_req_valid,
    input logic [num_msts-1:0] mst_req_write,
    input addr_t               mst_req_addr  [num_msts],
    input data_t               mst_req_wdata [num_msts],
    input logic [num_msts-1:0] mst_req_ready,

    input logic [num_msts-1:0] mst_rsp_valid,
    input data_t               mst_rsp_rdata [num_msts],
    input resp_t               mst_rsp_resp  [num_msts],

    input logic [num_slvs-1:0] slv_req,
    input logic                slv_write,
    input addr_t               slv_addr,
    input data_t               slv_wdata,

    input logic                pause_req,
    input logic                pause_ack,
    input arb_state_t          arb_state
);

    int unsigned err_count = 0;

    logic [num_msts-1:0] outst;
    logic [num_msts-1:0] acc_write;
    addr_t               acc_addr  [num_msts];
    data_t               acc_wdata [num_msts];
    int unsigned         last_grant;
    logic [num_msts-1:0] next_rr_mask;
    logic [num_msts-1:0] next_rr_q;

    // the map is one contiguous window of num_slvs regions.
    function automatic logic is_mapped(input addr_t a);
        return (a >= mmap_base) && ((a - mmap_base) < addr_t'(num_slvs) * mmap_stride);
    endfunction

    // regions are aligned, so clearing the in-region bits gives the base.
    function automatic addr_t region_start(input addr_t a);
        return a & ~(mmap_stride - addr_t'(1));
    endfunction

    function automatic logic [num_slvs-1:0] target_mask(input addr_t a);
        logic [num_slvs-1:0] m;
        m = '0;
        m[(a - mmap_base) / mmap_stride] = 1'b1;
        return m;
    endfunction

    always_comb begin
        next_rr_mask = '0;
        next_rr_mask[(last_grant + 1) % num_msts] = 1'b1;
    end

    // an access is open from its ready pulse until its response pulse.
    always_ff @(posedge hsdom_seq or negedge arst_n) begin
        if (!arst_n) begin
            outst      <= '0;
            last_grant <= num_msts - 1;
            next_rr_q  <= '0;
        end else begin
            next_rr_q <= next_rr_mask;
            for (int i = 0; i < num_msts; i++) begin
                if (mst_req_ready[i]) begin
                    outst[i]     <= 1'b1;
                    last_grant   <= i;
                    acc_addr[i]  <= mst_req_addr[i];
                    acc_write[i] <= mst_req_write[i];
                    acc_wdata[i] <= mst_req_wdata[i];
                end else if (mst_rsp_valid[i]) begin
                    outst[i] <= 1'b0;
                end
            end
        end
    end

    for (genvar i = 0; i < num_msts; i++) begin : g_mst
        logic  mapped;
        data_t exp_rdata;
        resp_t exp_resp;

        assign mapped    = is_mapped(acc_addr[i]);
        assign exp_rdata = mapped ? data_t'(region_start(acc_addr[i])) : '0;
        assign exp_resp  = mapped ? resp_okay : resp_decerr;

        a_rsp_owner: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_rsp_valid[i] |-> outst[i])
        else begin
            $error("master %0d got a response without an open request", i);
            err_count++;
        end

        a_rsp_resp: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_rsp_valid[i] |-> mst_rsp_resp[i] == exp_resp)
        else begin
            $error("FAILED t=%0t mst_rsp_resp[%0d]: got %0h expected %0h",
                $time, i, $sampled(mst_rsp_resp[i]), $sampled(exp_resp));
            err_count++;
        end

        // write data is not returned, except as zero on a decode error.
        a_rsp_rdata: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_rsp_valid[i] && !(acc_write[i] && mapped) |-> mst_rsp_rdata[i] == exp_rdata)
        else begin
            $error("FAILED t=%0t mst_rsp_rdata[%0d]: got %0h expected %0h",
                $time, i, $sampled(mst_rsp_rdata[i]), $sampled(exp_rdata));
            err_count++;
        end

        a_decerr: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_req_ready[i] && !is_mapped(mst_req_addr[i])
            |=> mst_rsp_valid[i] && (slv_req == '0))
        else begin
            $error("unmapped access of master %0d was not answered by the fabric in time", i);
            err_count++;
        end

        a_fwd_target: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_req_ready[i] && is_mapped(mst_req_addr[i])
            |=> slv_req == target_mask(acc_addr[i]))
        else begin
            $error("FAILED t=%0t slv_req: got %b expected %b",
                $time, $sampled(slv_req), target_mask($sampled(acc_addr[i])));
            err_count++;
        end

        a_fwd_addr: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_req_ready[i] && is_mapped(mst_req_addr[i]) |=> slv_addr == acc_addr[i])
        else begin
            $error("FAILED t=%0t slv_addr: got %0h expected %0h",
                $time, $sampled(slv_addr), $sampled(acc_addr[i]));
            err_count++;
        end

        a_fwd_write: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_req_ready[i] && is_mapped(mst_req_addr[i]) |=> slv_write == acc_write[i])
        else begin
            $error("FAILED t=%0t slv_write: got %0b expected %0b",
                $time, $sampled(slv_write), $sampled(acc_write[i]));
            err_count++;
        end

        a_fwd_wdata: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
            mst_req_ready[i] && mst_req_write[i] && is_mapped(mst_req_addr[i])
            |=> slv_wdata == acc_wdata[i])
        else begin
            $error("FAILED t=%0t slv_wdata: got %0h expected %0h",
                $time, $sampled(slv_wdata), $sampled(acc_wdata[i]));
            err_count++;
        end
    end

    a_slv_onehot: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
        $onehot0(slv_req))
    else begin
        $error("more than one target request in the same cycle");
        err_count++;
    end

    a_ready_excl: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
        |mst_req_ready |-> $onehot(mst_req_ready) && (outst == '0))
    else begin
        $error("request accepted while another access was still open");
        err_count++;
    end

    a_fair: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
        arb_state == arb_idle && !pause_req && (&mst_req_valid)
        |=> mst_req_ready == next_rr_q)
    else begin
        $error("FAILED t=%0t mst_req_ready: got %b expected %b",
            $time, $sampled(mst_req_ready), $sampled(next_rr_q));
        err_count++;
    end

    a_pause_quiet: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
        pause_ack |-> (mst_req_ready == '0) && (slv_req == '0) && (outst == '0))
    else begin
        $error("traffic or an open access while the pause was acknowledged");
        err_count++;
    end

    a_pause_resume: assert property (@(posedge hsdom_seq) disable iff (!arst_n)
        pause_ack && !pause_req && (|mst_req_valid) |-> ##2 (|mst_req_ready))
    else begin
        $error("granting did not resume after the pause request fell");
        err_count++;
    end

    a_reset_quiet: assert property (@(posedge hsdom_seq)
        (!arst_n || $rose(arst_n)) |-> (mst_req_ready == '0) && (mst_rsp_valid == '0)
            && (slv_req == '0) && !pause_ack && (arb_state == arb_idle))
    else begin
        $error("fabric outputs not quiet during or right after reset");
        err_count++;
    end

endmodule

// File: test/fabric_tb.sv
`timescale 1ns/1ps

module fabric_tb import bus_pkg::*, mmap_pkg::*; ();

    localparam int unsigned num_msts   = 3;
    localparam int unsigned num_slvs   = 4;
    localparam int unsigned quota      = 20;
    localparam int unsigned wait_limit = 400;
    localparam int unsigned run_limit  = 20000;

    logic                hsdom_seq;
    logic                arst_n;

    logic [num_msts-1:0] mst_req_valid;
    logic [num_msts-1:0] mst_req_write;
    addr_t               mst_req_addr  [num_msts];
    data_t               mst_req_wdata [num_msts];
    logic [num_msts-1:0] mst_req_ready;
    logic [num_msts-1:0] mst_rsp_valid;
    data_t               mst_rsp_rdata [num_msts];
    resp_t               mst_rsp_resp  [num_msts];

    logic [num_slvs-1:0] slv_req;
    logic                slv_write;
    addr_t               slv_addr;
    data_t               slv_wdata;
    logic [num_slvs-1:0] slv_rsp;
    data_t               slv_rdata [num_slvs];
    resp_t               slv_resp  [num_slvs];

    logic                pause_req;
    logic                pause_ack;

    logic [num_msts-1:0] mst_finished;

    always #2 hsdom_seq = ~hsdom_seq;

    fabric_top #(
        .num_msts (num_msts),
        .num_slvs (num_slvs)
    ) i_dut (.*);

    bind fabric_top fabric_props #(
        .num_msts (num_msts),
        .num_slvs (num_slvs)
    ) i_props (
        .*,
        .arb_state (i_arbiter.state)
    );

    // galois lfsr with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic int unsigned take_bits(inout logic [15:0] s, input int unsigned n);
        int unsigned v;
        v = 0;
        for (int unsigned b = 0; b < n; b++) begin
            v = (v << 1) | s[0];
            s = lfsr_step(s);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge hsdom_seq) begin
        if (i_dut.i_props.err_count != 0) begin
            abort_run("an assertion on the fabric failed");
        end
    end

    for (genvar m = 0; m < num_msts; m++) begin : g_master
        initial begin
            logic [15:0] rng;
            int unsigned waited;
            addr_t       addr;
            rng = 16'd51;
            // each master starts at its own point in the sequence.
            void'(take_bits(rng, 5 * m + 1));
            waited = 0;
            do begin
                @(posedge hsdom_seq);
                waited++;
            end while (!arst_n && waited < wait_limit);
            if (!arst_n) begin
                abort_run("reset was never released");
            end
            for (int unsigned n = 0; n < quota; n++) begin
                repeat (take_bits(rng, 2)) @(posedge hsdom_seq);
                if (take_bits(rng, 2) == 0) begin
                    case (take_bits(rng, 2))
                        0: addr = mmap_base - addr_t'(4);
                        1: addr = mmap_base + addr_t'(num_slvs) * mmap_stride
                                  + addr_t'(take_bits(rng, 10) << 2);
                        2: addr = addr_t'(32'h8000_0000);
                        default: addr = addr_t'(32'h0000_0010);
                    endcase
                end else begin
                    addr = mmap_base + addr_t'(take_bits(rng, 2)) * mmap_stride
                           + addr_t'(take_bits(rng, 10) << 2);
                end
                @(posedge hsdom_seq);
                mst_req_valid[m] <= 1'b1;
                mst_req_write[m] <= (take_bits(rng, 1) != 0);
                mst_req_addr[m]  <= addr;
                mst_req_wdata[m] <= data_t'(take_bits(rng, 16));
                waited = 0;
                do begin
                    @(posedge hsdom_seq);
                    waited++;
                end while (!mst_req_ready[m] && waited < wait_limit);
                if (!mst_req_ready[m]) begin
                    abort_run($sformatf("master %0d was never granted", m));
                end
                mst_req_valid[m] <= 1'b0;
                waited = 0;
                do begin
                    @(posedge hsdom_seq);
                    waited++;
                end while (!mst_rsp_valid[m] && waited < wait_limit);
                if (!mst_rsp_valid[m]) begin
                    abort_run($sformatf("master %0d never got its response", m));
                end
            end
            mst_finished[m] = 1'b1;
        end
    end

    for (genvar t = 0; t < num_slvs; t++) begin : g_target
        logic [15:0] rng;
        int unsigned lat;

        initial begin
            rng = 16'd51;
            void'(take_bits(rng, 4 * t + 3));
        end

        // the stub answers one to four cycles after its request.
        always @(posedge hsdom_seq) begin
            if (slv_req[t]) begin
                lat = take_bits(rng, 2) + 1;
                repeat (lat - 1) @(posedge hsdom_seq);
                slv_rsp[t]   <= 1'b1;
                slv_rdata[t] <= mmap_base + addr_t'(t) * mmap_stride;
                slv_resp[t]  <= resp_okay;
                @(posedge hsdom_seq);
                slv_rsp[t]   <= 1'b0;
            end
        end
    end

    initial begin
        int unsigned waited;
        hsdom_seq     = 1'b0;
        arst_n        <= 1'b0;
        pause_req     = 1'b0;
        mst_req_valid = '0;
        mst_req_write = '0;
        slv_rsp       = '0;
        mst_finished  = '0;
        for (int i = 0; i < num_msts; i++) begin
            mst_req_addr[i]  = '0;
            mst_req_wdata[i] = '0;
        end
        for (int j = 0; j < num_slvs; j++) begin
            slv_rdata[j] = '0;
            slv_resp[j]  = resp_okay;
        end
        repeat (5) @(posedge hsdom_seq);
        arst_n <= 1'b1;
        // let traffic build up, then pause while the masters keep asking.
        repeat (60) @(posedge hsdom_seq);
        pause_req <= 1'b1;
        repeat (40) @(posedge hsdom_seq);
        pause_req <= 1'b0;
        waited = 0;
        while (mst_finished != '1 && waited < run_limit) begin
            @(posedge hsdom_seq);
            waited++;
        end
        if (mst_finished != '1) begin
            abort_run("the masters did not finish their accesses in time");
        end
        repeat (8) @(posedge hsdom_seq);
        if (i_dut.i_props.err_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "assertion failures were counted");
        end
    end

endmodule

// File: tb.f
logic/bus_pkg.sv
logic/mmap_pkg.sv
logic/fabric_arbiter.sv
logic/fabric_decoder.sv
logic/fabric_top.sv
test/fabric_props.sv
test/fabric_tb.sv

// File: Bender.yml
package:
  name: hsdom_fabric

sources:
  # packages come first, the fabric modules depend on them.
  - logic/bus_pkg.sv
  - logic/mmap_pkg.sv
  - logic/fabric_arbiter.sv
  - logic/fabric_decoder.sv
  - logic/fabric_top.sv

  - target: test
    files:
      - test/fabric_props.sv
      - test/fabric_tb.sv
